//--- opb_pkg.sv
package opb_pkg;

  localparam int data_w = 32;
  localparam int addr_w = 32;
  localparam int be_w   = data_w / 8;

  // OPB numbering, bit 0 is the msb
  typedef logic [0:data_w-1] data_t;

  // addresses are compared and subtracted as plain numbers
  typedef logic [addr_w-1:0] addr_t;

  // be[0] covers data bits 0 to 7
  typedef logic [0:be_w-1] be_t;

  // word index from offset bits 5:2
  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t reg_id      = 4'd0;  // board id, major rev
  localparam reg_idx_t reg_rev     = 4'd1;  // minor rev, rcs rev
  localparam reg_idx_t reg_ctrl    = 4'd2;  // soft reset, rcs flag
  localparam reg_idx_t reg_scratch = 4'd3;
  localparam reg_idx_t reg_count   = 4'd4;  // fab_clk cycle count

endpackage

//--- sys_pkg.sv
package sys_pkg;

  localparam int count_w = 32;

  // free-running fab_clk cycle count
  typedef logic [count_w-1:0] count_t;

  // OPB side of the four-phase counter crossing
  typedef enum logic [1:0] {
    cap_idle,     // waiting for a counter read
    cap_request,  // req high, waiting for got
    cap_release   // req low, waiting for got to drop
  } capture_state_t;

  localparam opb_pkg::data_t scratch_reset = 32'h1234_5678;

endpackage

//--- opb_req_if.sv
interface opb_req_if;
  import opb_pkg::*;

  logic     wr_stb;  // one cycle per write
  reg_idx_t idx;
  be_t      be;
  data_t    wdata;
  logic     rd_en;   // high while read data is shown
  data_t    rdata;

  modport ctrl (
    output wr_stb,
    output idx,
    output be,
    output wdata,
    output rd_en,
    input  rdata
  );

  modport regs (
    input  wr_stb,
    input  idx,
    input  be,
    input  wdata,
    input  rd_en,
    output rdata
  );

endinterface

//--- opb_slave_ctrl.sv
module opb_slave_ctrl #(
  parameter opb_pkg::addr_t base_addr = 32'h0000_0000,
  parameter opb_pkg::addr_t high_addr = 32'h0000_ffff
) (
  input  logic           OPB_Clk,
  input  logic           reset,
  input  opb_pkg::addr_t abus,
  input  opb_pkg::be_t   be,
  input  opb_pkg::data_t dbus,
  input  logic           rnw,
  input  logic           select,
  input  logic           capture_done,
  output logic           xfer_ack,
  output logic           capture_start,
  output opb_pkg::data_t sl_dbus,
  opb_req_if.ctrl        bus
);
  import opb_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_ack,
    st_wait_cap
  } state_t;

  state_t   state;
  addr_t    offset;
  reg_idx_t idx;
  logic     in_window;
  logic     accept;
  logic     count_read;
  logic     rd_access;

  assign in_window = (abus >= base_addr) && (abus <= high_addr);
  assign offset    = abus - base_addr;
  assign idx       = offset[5:2];

  // idle also means xfer_ack is low
  assign accept = (state == st_idle) && select && in_window;

  // only a read with the low byte lane enabled refreshes the count
  assign count_read = rnw && (idx == reg_count) && be[0];

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state         <= st_idle;
      capture_start <= 1'b0;
      rd_access     <= 1'b0;
    end else begin
      capture_start <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            rd_access <= rnw;
            if (count_read) begin
              state         <= st_wait_cap;
              capture_start <= 1'b1;
            end else begin
              state <= st_ack;
            end
          end
        end
        st_wait_cap: begin
          if (capture_done) begin
            state <= st_ack;  // ack one cycle after done
          end
        end
        st_ack: begin
          state <= st_idle;  // no accept in the ack cycle
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign xfer_ack = (state == st_ack);

  // writes land on the accepting edge
  assign bus.wr_stb = accept && !rnw;
  assign bus.idx    = idx;
  assign bus.be     = be;
  assign bus.wdata  = dbus;
  assign bus.rd_en  = xfer_ack && rd_access;

  assign sl_dbus = xfer_ack ? bus.rdata : {data_w{1'b0}};

endmodule

//--- sys_reg_file.sv
module sys_reg_file #(
  parameter logic [15:0] board_id     = 16'h0000,
  parameter logic [15:0] rev_major    = 16'h0000,
  parameter logic [15:0] rev_minor    = 16'h0000,
  parameter logic [15:0] rev_rcs      = 16'h0000,
  parameter logic        rcs_uptodate = 1'b0
) (
  input  logic            OPB_Clk,
  input  logic            reset,
  input  sys_pkg::count_t latched_count,
  output logic            soft_reset,
  opb_req_if.regs         bus
);
  import opb_pkg::*;
  import sys_pkg::*;

  data_t scratch;
  logic  ctrl_wr;
  logic  scratch_wr;

  assign ctrl_wr    = bus.wr_stb && (bus.idx == reg_ctrl);
  assign scratch_wr = bus.wr_stb && (bus.idx == reg_scratch);

  // byte lanes follow be, lane 0 is bits 0 to 7
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      scratch <= scratch_reset;
    end else if (scratch_wr) begin
      for (int i = 0; i < be_w; i++) begin
        if (bus.be[i]) begin
          scratch[8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // pulse lines up with the bus ack
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      soft_reset <= 1'b0;
    end else if (ctrl_wr && bus.be[3]) begin
      soft_reset <= bus.wdata[31];
    end else begin
      soft_reset <= 1'b0;
    end
  end

  always_comb begin
    bus.rdata = {data_w{1'b0}};
    if (bus.rd_en) begin
      case (bus.idx)
        reg_id: begin
          bus.rdata = {board_id, rev_major};
        end
        reg_rev: begin
          bus.rdata = {rev_minor, rev_rcs};
        end
        reg_ctrl: begin
          bus.rdata = {15'b0, rcs_uptodate, 15'b0, soft_reset};  // bits 15 and 31
        end
        reg_scratch: begin
          bus.rdata = scratch;
        end
        reg_count: begin
          bus.rdata = latched_count;
        end
        default: begin
          bus.rdata = {data_w{1'b0}};
        end
      endcase
    end
  end

endmodule

//--- count_capture.sv
module count_capture (
  input  logic            OPB_Clk,
  input  logic            reset,
  input  logic            capture_start,
  input  logic            cnt_got,
  input  sys_pkg::count_t cnt_value,
  output logic            capture_done,
  output logic            cnt_req,
  output sys_pkg::count_t latched_count
);
  import sys_pkg::*;

  capture_state_t state;
  logic           got_meta;
  logic           got_sync;

  // got comes from the fab_clk domain
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      got_meta <= 1'b0;
      got_sync <= 1'b0;
    end else begin
      got_meta <= cnt_got;
      got_sync <= got_meta;
    end
  end

  // cnt_req is a flop so nothing glitches across the crossing
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state   <= cap_idle;
      cnt_req <= 1'b0;
    end else begin
      case (state)
        cap_idle: begin
          if (capture_start) begin
            state   <= cap_request;
            cnt_req <= 1'b1;
          end
        end
        cap_request: begin
          if (got_sync) begin
            state   <= cap_release;
            cnt_req <= 1'b0;
          end
        end
        cap_release: begin
          if (!got_sync) begin
            state <= cap_idle;
          end
        end
        default: begin
          state   <= cap_idle;
          cnt_req <= 1'b0;
        end
      endcase
    end
  end

  // value is stable while got is high
  always_ff @(posedge OPB_Clk) begin
    if (state == cap_request && got_sync) begin
      latched_count <= cnt_value;
    end
  end

  assign capture_done = (state == cap_release) && !got_sync;

endmodule

//--- fab_cycle_counter.sv
module fab_cycle_counter (
  input  logic            fab_clk,
  input  logic            reset,
  input  logic            cnt_req,
  output logic            cnt_got,
  output sys_pkg::count_t cnt_value
);
  import sys_pkg::*;

  logic   rst_meta;
  logic   rst_sync;
  logic   req_meta;
  logic   req_sync;
  count_t count;

  // bring reset and req over from OPB_Clk
  always_ff @(posedge fab_clk) begin
    rst_meta <= reset;
    rst_sync <= rst_meta;
    req_meta <= cnt_req;
    req_sync <= req_meta;
  end

  always_ff @(posedge fab_clk) begin
    if (rst_sync) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge fab_clk) begin
    if (rst_sync) begin
      cnt_got <= 1'b0;
    end else if (req_sync && !cnt_got) begin
      cnt_value <= count;  // snapshot, held until req drops
      cnt_got   <= 1'b1;
    end else if (!req_sync) begin
      cnt_got <= 1'b0;
    end
  end

endmodule

//--- sys_block.sv
module sys_block #(
  parameter logic [15:0]    board_id     = 16'h0000,
  parameter logic [15:0]    rev_major    = 16'h0000,
  parameter logic [15:0]    rev_minor    = 16'h0000,
  parameter logic [15:0]    rev_rcs      = 16'h0000,
  parameter logic           rcs_uptodate = 1'b0,
  parameter opb_pkg::addr_t base_addr    = 32'h0000_0000,
  parameter opb_pkg::addr_t high_addr    = 32'h0000_ffff
) (
  input  logic           OPB_Clk,
  input  logic           reset,
  input  logic           fab_clk,
  input  opb_pkg::addr_t opb_abus,
  input  opb_pkg::be_t   opb_be,
  input  opb_pkg::data_t opb_dbus,
  input  logic           opb_rnw,
  input  logic           opb_select,
  input  logic           opb_seqaddr,  // bursts not supported
  output opb_pkg::data_t sl_dbus,
  output logic           sl_xferack,
  output logic           sl_errack,
  output logic           sl_retry,
  output logic           sl_toutsup,
  output logic           soft_reset
);
  import sys_pkg::*;

  logic   capture_start;
  logic   capture_done;
  logic   cnt_req;
  logic   cnt_got;
  count_t cnt_value;
  count_t latched_count;

  opb_req_if req_if ();

  // never retry, error or stretch the timeout
  assign sl_errack  = 1'b0;
  assign sl_retry   = 1'b0;
  assign sl_toutsup = 1'b0;

  opb_slave_ctrl #(
    .base_addr(base_addr),
    .high_addr(high_addr)
  ) ctrl_i (
    .OPB_Clk      (OPB_Clk),
    .reset        (reset),
    .abus         (opb_abus),
    .be           (opb_be),
    .dbus         (opb_dbus),
    .rnw          (opb_rnw),
    .select       (opb_select),
    .capture_done (capture_done),
    .xfer_ack     (sl_xferack),
    .capture_start(capture_start),
    .sl_dbus      (sl_dbus),
    .bus          (req_if.ctrl)
  );

  sys_reg_file #(
    .board_id    (board_id),
    .rev_major   (rev_major),
    .rev_minor   (rev_minor),
    .rev_rcs     (rev_rcs),
    .rcs_uptodate(rcs_uptodate)
  ) regs_i (
    .OPB_Clk      (OPB_Clk),
    .reset        (reset),
    .latched_count(latched_count),
    .soft_reset   (soft_reset),
    .bus          (req_if.regs)
  );

  count_capture capture_i (
    .OPB_Clk      (OPB_Clk),
    .reset        (reset),
    .capture_start(capture_start),
    .cnt_got      (cnt_got),
    .cnt_value    (cnt_value),
    .capture_done (capture_done),
    .cnt_req      (cnt_req),
    .latched_count(latched_count)
  );

  fab_cycle_counter counter_i (
    .fab_clk  (fab_clk),
    .reset    (reset),
    .cnt_req  (cnt_req),
    .cnt_got  (cnt_got),
    .cnt_value(cnt_value)
  );

endmodule

//--- sys_block_props.sv
module sys_block_props (
  input logic                    OPB_Clk,
  input logic                    reset,
  input logic                    xfer_ack,
  input opb_pkg::data_t          sl_dbus,
  input logic                    cnt_req,
  input logic                    got_sync,
  input sys_pkg::capture_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;
  import sys_pkg::*;

  int unsigned fails = 0;

  ack_single: assert property (@(posedge OPB_Clk) disable iff (reset)
    xfer_ack |=> !xfer_ack)
    else begin
      $error("xfer_ack high for two cycles");
      fails++;
    end

  dbus_idle: assert property (@(posedge OPB_Clk) disable iff (reset)
    !xfer_ack |-> (sl_dbus == '0))
    else begin
      $error("sl_dbus not zero outside the ack cycle");
      fails++;
    end

  // req may only drop once got has come through the synchronizer
  req_hold: assert property (@(posedge OPB_Clk) disable iff (reset)
    (state == cap_request && !got_sync) |=> cnt_req)
    else begin
      $error("cnt_req dropped before got was seen");
      fails++;
    end

endmodule

bind opb_slave_ctrl sys_block_props bus_props_i (.OPB_Clk(OPB_Clk), .reset(reset),
  .xfer_ack(xfer_ack), .sl_dbus(sl_dbus), .cnt_req(1'b0), .got_sync(1'b0),
  .state(sys_pkg::cap_idle));

bind count_capture sys_block_props cap_props_i (.OPB_Clk(OPB_Clk), .reset(reset),
  .xfer_ack(1'b0), .sl_dbus('0), .cnt_req(cnt_req), .got_sync(got_sync),
  .state(state));

//--- sys_block_tb.sv
module sys_block_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import opb_pkg::*;
  import sys_pkg::*;

  localparam logic [15:0] board_id     = 16'hA5C3;
  localparam logic [15:0] rev_major    = 16'h0002;
  localparam logic [15:0] rev_minor    = 16'h0007;
  localparam logic [15:0] rev_rcs      = 16'h1234;
  localparam logic        rcs_uptodate = 1'b1;
  localparam addr_t       base_addr    = 32'h8000_0000;
  localparam addr_t       high_addr    = 32'h8000_FFFF;

  logic  OPB_Clk = 1'b0;
  logic  fab_clk = 1'b0;
  logic  reset = 1'b1;
  addr_t opb_abus = '0;
  be_t   opb_be = '0;
  data_t opb_dbus = '0;
  logic  opb_rnw = 1'b0;
  logic  opb_select = 1'b0;
  logic  opb_seqaddr = 1'b0;
  data_t sl_dbus;
  logic  sl_xferack, sl_errack, sl_retry, sl_toutsup, soft_reset;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int unsigned fab_edges = 0;
  int unsigned ack_edges = 0;  // fab edge count at the last ack
  int          sr_pulses = 0;
  int          sr_stray = 0;
  int unsigned seed_val;

  sys_block #(
    .board_id(board_id), .rev_major(rev_major), .rev_minor(rev_minor),
    .rev_rcs(rev_rcs), .rcs_uptodate(rcs_uptodate),
    .base_addr(base_addr), .high_addr(high_addr)
  ) dut_i (.*);

  always #10 OPB_Clk = ~OPB_Clk;
  always #7 fab_clk = ~fab_clk;
  always @(posedge fab_clk) fab_edges++;

  always @(negedge OPB_Clk) begin
    if (soft_reset === 1'b1) begin
      sr_pulses++;
      if (sl_xferack !== 1'b1) sr_stray++;  // must sit on the ack
    end
  end

  // unused replies stay low
  always @(negedge OPB_Clk) begin
    if (sl_errack !== 1'b0 || sl_retry !== 1'b0 || sl_toutsup !== 1'b0) begin
      $display("reply check: errack, retry or toutsup is not low at %0t", $time);
      errors++;
    end
  end

  function automatic addr_t reg_addr(int idx);
    return base_addr + addr_t'(idx * 4);
  endfunction

  function automatic data_t id_word();
    data_t w;
    w[0:15]  = board_id;
    w[16:31] = rev_major;
    return w;
  endfunction

  task automatic report_mismatch(string test, data_t exp, data_t act);
    $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
    errors++;
  endtask

  task automatic finish_test(string name, int errs_at_start);
    tests_run++;
    if (errors != errs_at_start) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // select is held until the ack cycle
  task automatic bus_transfer(addr_t addr, be_t be, logic rnw, data_t wdata,
                              output data_t rdata, output logic ok);
    ok    = 1'b0;
    rdata = '0;
    @(posedge OPB_Clk);
    #2;
    opb_abus   = addr;
    opb_be     = be;
    opb_rnw    = rnw;
    opb_dbus   = rnw ? '0 : wdata;
    opb_select = 1'b1;
    for (int i = 0; i < 200 && !ok; i++) begin
      @(negedge OPB_Clk);
      if (sl_xferack) begin
        ok        = 1'b1;
        rdata     = sl_dbus;
        ack_edges = fab_edges;
      end
    end
    if (!ok) begin
      $display("bus timeout: no acknowledge for address %h within 200 cycles", addr);
      errors++;
    end
    @(posedge OPB_Clk);
    #2;
    opb_select = 1'b0;
    opb_rnw    = 1'b0;
    opb_be     = '0;
    opb_dbus   = '0;
  endtask

  task automatic opb_write(addr_t addr, be_t be, data_t wdata);
    data_t unused;
    logic  ok;
    bus_transfer(addr, be, 1'b0, wdata, unused, ok);
  endtask

  task automatic opb_read(addr_t addr, be_t be, output data_t rdata, output logic ok);
    bus_transfer(addr, be, 1'b1, '0, rdata, ok);
  endtask

  task automatic probe_no_ack(addr_t addr);
    logic seen;
    seen = 1'b0;
    @(posedge OPB_Clk);
    #2;
    opb_abus   = addr;
    opb_be     = '1;
    opb_rnw    = 1'b1;
    opb_select = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge OPB_Clk);
      if (sl_xferack) seen = 1'b1;
    end
    @(posedge OPB_Clk);
    #2;
    opb_select = 1'b0;
    opb_rnw    = 1'b0;
    if (seen) begin
      $display("decode test: address %h outside the window was acknowledged", addr);
      errors++;
    end
  endtask

  task automatic identity_words();
    data_t exp, got;
    logic  ok;
    int    start;
    start = errors;
    exp = id_word();
    opb_read(reg_addr(reg_id), '1, got, ok);
    if (ok && got !== exp) report_mismatch("identity", exp, got);
    exp[0:15]  = rev_minor;
    exp[16:31] = rev_rcs;
    opb_read(reg_addr(reg_rev), '1, got, ok);
    if (ok && got !== exp) report_mismatch("identity", exp, got);
    exp     = '0;
    exp[15] = rcs_uptodate;
    opb_read(reg_addr(reg_ctrl), '1, got, ok);
    if (ok && got !== exp) report_mismatch("identity", exp, got);
    for (int i = 5; i < 16; i++) begin
      opb_read(reg_addr(i), '1, got, ok);
      if (ok && got !== '0) report_mismatch("identity", '0, got);
    end
    finish_test("identity", start);
  endtask

  task automatic scratch_lanes();
    data_t exp, got, wdata;
    be_t   be;
    logic  ok;
    int    start;
    start = errors;
    exp = scratch_reset;
    opb_read(reg_addr(reg_scratch), '1, got, ok);
    if (ok && got !== exp) report_mismatch("scratch", exp, got);
    repeat (10) begin
      wdata = $urandom;
      be    = $urandom;
      opb_write(reg_addr(reg_scratch), be, wdata);
      for (int i = 0; i < 4; i++) begin
        if (be[i]) exp[8*i +: 8] = wdata[8*i +: 8];  // lane 0 is bits 0 to 7
      end
      opb_read(reg_addr(reg_scratch), '1, got, ok);
      if (ok && got !== exp) report_mismatch("scratch", exp, got);
    end
    finish_test("scratch", start);
  endtask

  task automatic soft_reset_strobe();
    data_t wdata;
    be_t   be;
    int    start, pulses0, stray0;
    start   = errors;
    stray0  = sr_stray;
    wdata   = '0;
    wdata[31] = 1'b1;
    be      = '0;
    be[3]   = 1'b1;
    pulses0 = sr_pulses;
    opb_write(reg_addr(reg_ctrl), be, wdata);
    repeat (3) @(negedge OPB_Clk);
    if (sr_pulses - pulses0 != 1) report_mismatch("soft_reset", 1, sr_pulses - pulses0);
    be      = '1;
    be[3]   = 1'b0;
    pulses0 = sr_pulses;
    opb_write(reg_addr(reg_ctrl), be, wdata);
    repeat (3) @(negedge OPB_Clk);
    if (sr_pulses != pulses0) report_mismatch("soft_reset", 0, sr_pulses - pulses0);
    if (sr_stray != stray0) begin
      $display("soft_reset test: pulse seen outside the acknowledge cycle");
      errors++;
    end
    finish_test("soft_reset", start);
  endtask

  task automatic counter_reads();
    data_t       c1, c2, c3;
    be_t         be;
    logic        ok1, ok2, ok3;
    int unsigned e1, e2, diff, edges;
    int          start;
    start = errors;
    opb_read(reg_addr(reg_count), '1, c1, ok1);
    e1 = ack_edges;
    opb_read(reg_addr(reg_count), '1, c2, ok2);
    e2 = ack_edges;
    if (ok1 && ok2) begin
      if (c2 <= c1) begin
        $display("counter test: second count %h is not above first count %h", c2, c1);
        errors++;
      end
      diff  = c2 - c1;
      edges = e2 - e1;
      if (diff > edges + 8 || diff + 8 < edges) report_mismatch("counter", edges, diff);
    end
    be    = '1;
    be[0] = 1'b0;  // no capture, old value comes back
    opb_read(reg_addr(reg_count), be, c3, ok3);
    if (ok3 && c3 !== c2) report_mismatch("counter", c2, c3);
    finish_test("counter", start);
  endtask

  task automatic window_decode();
    data_t got;
    logic  ok;
    int    start;
    start = errors;
    probe_no_ack(32'h7FFF_FFFC);
    probe_no_ack(32'h8001_0000);
    opb_write(reg_addr(reg_id), '1, 32'hFFFF_FFFF);
    opb_read(reg_addr(reg_id), '1, got, ok);
    if (ok && got !== id_word()) report_mismatch("decode", id_word(), got);
    finish_test("decode", start);
  endtask

  initial begin
    seed_val = $urandom(32'h7b1c);
    repeat (5) @(posedge OPB_Clk);
    #2;
    reset = 1'b0;
    identity_words();
    scratch_lanes();
    soft_reset_strobe();
    counter_reads();
    window_decode();
    errors += dut_i.ctrl_i.bus_props_i.fails + dut_i.capture_i.cap_props_i.fails;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
opb_pkg.sv
sys_pkg.sv
opb_req_if.sv
opb_slave_ctrl.sv
sys_reg_file.sv
count_capture.sv
fab_cycle_counter.sv
sys_block.sv
sys_block_props.sv
sys_block_tb.sv
